/* files.f */
design/i2s_pkg.sv
design/i2s_clock_gen.sv
design/i2s_transmitter.sv
design/i2s_receiver.sv
design/i2s_axil_regs.sv
design/i2s_codec_top.sv
tb/i2s_properties.sv
tb/i2s_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= i2s_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and check the log"
	@echo "make clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/i2s_tb.sv */
`timescale 1ns/1ps

module i2s_tb;

  localparam int N_FRAMES     = 10;
  localparam int WATCHDOG_CYC = N_FRAMES * 2 * i2s_pkg::LRCLK_HALF + 2000;
  localparam int WAIT_LIMIT   = 2 * i2s_pkg::LRCLK_HALF + 200;

  logic        clk_i, rst_ni;
  logic [7:0]  awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [1:0]  bresp, rresp;
  logic        mclk, bclk, lrclk, adc_sdata, dac_sdata, rx_valid;

  // Codec model state
  logic [15:0] lfsr_state;
  logic [15:0] cur_word, sent_left, sent_right;
  logic [24:0] dac_shift, cap_left, cap_right;
  logic        prev_bclk, prev_lr, lr_chg, rise;
  int          dac_idx, adc_idx, left_words, right_words;

  string       cur_test;
  int          tests, checks, errors, test_errs;
  logic [1:0]  resp;
  logic [31:0] data, exp_l, exp_r;
  int          l0, r0, n;

  i2s_codec_top dut_i (
    .clk_i, .rst_ni,
    .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
    .s_axil_wdata_i(wdata), .s_axil_wvalid_i(wvalid), .s_axil_wready_o(wready),
    .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid), .s_axil_bready_i(bready),
    .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid), .s_axil_arready_o(arready),
    .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp), .s_axil_rvalid_o(rvalid),
    .s_axil_rready_i(rready),
    .mclk_o(mclk), .bclk_o(bclk), .lrclk_o(lrclk), .adc_sdata_i(adc_sdata),
    .dac_sdata_o(dac_sdata), .rx_valid_o(rx_valid)
  );

  bind i2s_codec_top i2s_properties props_i (
    .clk_i, .rst_ni, .awaddr_i(s_axil_awaddr_i), .awvalid_i(s_axil_awvalid_i),
    .awready_i(s_axil_awready_o), .wdata_lsb_i(s_axil_wdata_i[0]),
    .wvalid_i(s_axil_wvalid_i), .wready_i(s_axil_wready_o),
    .adc_sdata_i, .dac_sdata_i(dac_sdata_o),
    .rx_valid_i(rx_valid), .bvalid_i(s_axil_bvalid_o), .bready_i(s_axil_bready_i),
    .rvalid_i(s_axil_rvalid_o), .rready_i(s_axil_rready_i), .bclk_i(bclk_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Codec side: sample DAC on bit-clock rises, drive ADC after each rise
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      prev_bclk = 1'b0;
      prev_lr   = 1'b0;
      dac_idx   = 99;
      adc_idx   = 99;
      adc_sdata = 1'b0;
    end else begin
      lr_chg = lrclk !== prev_lr;
      rise   = bclk && !prev_bclk;
      if (lr_chg) begin
        dac_idx = 0;
        adc_idx = 0;
        for (int i = 0; i < 16; i++) begin
          cur_word   = {cur_word[14:0], lfsr_state[0]};  // One step per bit
          lfsr_state = lfsr_next(lfsr_state);
        end
        if (lrclk) sent_right = cur_word;
        else       sent_left  = cur_word;
      end
      if (rise) begin
        if (dac_idx < 25) begin
          dac_shift = {dac_shift[23:0], dac_sdata};
          dac_idx++;
          if (dac_idx == 25 && lrclk) begin
            cap_right = dac_shift;
            right_words++;
          end else if (dac_idx == 25) begin
            cap_left = dac_shift;
            left_words++;
          end
        end
        if (!lr_chg && adc_idx < 99) adc_idx++;
        // First rise after the word-select edge is the delay slot
        adc_sdata = (adc_idx >= 1 && adc_idx <= 16) ? cur_word[16-adc_idx] : 1'b0;
      end
      prev_bclk = bclk;
      prev_lr   = lrclk;
    end
  end

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("Error: %s %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic report_stall(input string what);
    $display("%s: %s did not happen in time", cur_test, what);
    errors++;
    test_errs++;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    tests++;
    $display("test %-10s %s", cur_test, (test_errs == 0) ? "ok" : "failed");
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] d, output logic [1:0] r);
    int k;
    @(negedge clk_i);
    awaddr  = addr;
    wdata   = d;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    for (k = 0; k < 50 && !(awready && wready); k++) @(negedge clk_i);
    if (!(awready && wready)) report_stall("write address and data ready");
    @(negedge clk_i);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    for (k = 0; k < 50 && !bvalid; k++) @(negedge clk_i);
    if (!bvalid) report_stall("write response");
    r = bresp;
    @(negedge clk_i);  // Response waits one cycle on bready
    bready = 1'b1;
    @(negedge clk_i);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] d, output logic [1:0] r);
    int k;
    @(negedge clk_i);
    araddr  = addr;
    arvalid = 1'b1;
    for (k = 0; k < 50 && !arready; k++) @(negedge clk_i);
    if (!arready) report_stall("read address ready");
    @(negedge clk_i);
    arvalid = 1'b0;
    for (k = 0; k < 50 && !rvalid; k++) @(negedge clk_i);
    if (!rvalid) report_stall("read response");
    d = rdata;
    r = rresp;
    @(negedge clk_i);  // Read data waits one cycle on rready
    rready = 1'b1;
    @(negedge clk_i);
    rready = 1'b0;
  endtask

  task automatic wait_frame_start();
    int k;
    for (k = 0; k < WAIT_LIMIT && lrclk !== 1'b1; k++) @(negedge clk_i);
    for (k = 0; k < WAIT_LIMIT && lrclk !== 1'b0; k++) @(negedge clk_i);
    if (lrclk !== 1'b0) report_stall("word-select fall");
  endtask

  task automatic wait_dac_frame();
    int k;
    l0 = left_words;
    r0 = right_words;
    for (k = 0; k < WAIT_LIMIT && !(left_words > l0 && right_words > r0); k++)
      @(negedge clk_i);
    if (!(left_words > l0 && right_words > r0)) report_stall("DAC frame");
  endtask

  task automatic wait_rx_valid();
    int k;
    @(negedge clk_i);
    for (k = 0; k < WAIT_LIMIT && !rx_valid; k++) @(negedge clk_i);
    if (!rx_valid) report_stall("rx_valid pulse");
  endtask

  initial begin
    {awaddr, araddr, wdata, awvalid, wvalid, bready, arvalid, rready} = '0;
    adc_sdata   = 1'b0;
    rst_ni      = 1'b0;
    lfsr_state  = 16'd36164;
    {cur_word, sent_left, sent_right} = '0;
    {dac_shift, cap_left, cap_right}  = '0;
    {left_words, right_words, tests, checks, errors} = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    start_test("reset");
    for (n = 1; n < i2s_pkg::BCLK_HALF; n++) begin
      @(negedge clk_i);
      check_val("clocks and pins", 0, {bclk, lrclk, dac_sdata, rx_valid});
      check_val("mclk", n % 2, mclk);  // Half the system clock, low in reset
    end
    for (n = 0; n <= 8'h14; n += 4) begin
      axi_read(8'(n), data, resp);
      check_val($sformatf("reg %02h", n), 0, data);
    end
    finish_test();

    start_test("registers");
    axi_write(i2s_pkg::REG_TX_LEFT, 32'hFFAB_CDEF, resp);
    check_val("write resp", 2'b00, resp);
    axi_read(i2s_pkg::REG_TX_LEFT, data, resp);
    check_val("tx left", 32'h00AB_CDEF, data);
    axi_write(i2s_pkg::REG_TX_RIGHT, 32'h1234_5678, resp);
    axi_read(i2s_pkg::REG_TX_RIGHT, data, resp);
    check_val("tx right", 32'h0034_5678, data);
    axi_write(8'h20, 32'h1, resp);
    check_val("unmapped write resp", 2'b10, resp);
    axi_read(8'h20, data, resp);
    check_val("unmapped read resp", 2'b10, resp);
    finish_test();

    start_test("transmit");
    axi_write(i2s_pkg::REG_TX_LEFT, 32'h00A5_C396, resp);
    axi_write(i2s_pkg::REG_TX_RIGHT, 32'h003C_0FE1, resp);
    wait_frame_start();
    wait_dac_frame();
    check_val("dac left", {1'b0, 24'hA5C396}, cap_left);   // Delay bit then MSB first
    check_val("dac right", {1'b0, 24'h3C0FE1}, cap_right);
    finish_test();

    start_test("receive");
    wait_rx_valid();
    wait_rx_valid();  // Second frame has a model word on both channels
    exp_l = sent_left;
    exp_r = sent_right;
    axi_read(i2s_pkg::REG_RX_LEFT, data, resp);
    check_val("rx left", exp_l, data);
    axi_read(i2s_pkg::REG_RX_RIGHT, data, resp);
    check_val("rx right", exp_r, data);
    axi_read(i2s_pkg::REG_STATUS, data, resp);
    check_val("status set", 1, data);
    axi_write(i2s_pkg::REG_STATUS, 32'h1, resp);
    axi_read(i2s_pkg::REG_STATUS, data, resp);
    check_val("status cleared", 0, data);
    finish_test();

    start_test("loopback");
    axi_write(i2s_pkg::REG_CTRL, 32'h1, resp);
    axi_read(i2s_pkg::REG_CTRL, data, resp);
    check_val("ctrl", 1, data);
    wait_frame_start();
    wait_dac_frame();  // A full frame of ADC words runs through the loop
    axi_write(i2s_pkg::REG_CTRL, 32'h0, resp);
    wait_frame_start();
    wait_dac_frame();
    check_val("dac left", {1'b0, 24'hA5C396}, cap_left);
    check_val("dac right", {1'b0, 24'h3C0FE1}, cap_right);
    finish_test();

    errors += dut_i.props_i.fails;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Backstop against a stalled run
  initial begin
    #(WATCHDOG_CYC * 20);
    $display("Timeout: run exceeded %0d clock cycles", WATCHDOG_CYC);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* tb/i2s_properties.sv */
`timescale 1ns/1ps

module i2s_properties (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic [i2s_pkg::ADDR_WIDTH-1:0] awaddr_i,
  input logic                           awvalid_i,
  input logic                           awready_i,
  input logic                           wdata_lsb_i,
  input logic                           wvalid_i,
  input logic                           wready_i,
  input logic                           adc_sdata_i,
  input logic                           dac_sdata_i,
  input logic                           rx_valid_i,
  input logic                           bvalid_i,
  input logic                           bready_i,
  input logic                           rvalid_i,
  input logic                           rready_i,
  input logic                           bclk_i
);

  int unsigned fails = 0;
  int          since_toggle;  // Cycles since the last bit-clock edge
  logic        loopback_q;    // Loopback bit as last written over the bus

  // First half period follows reset, so start one behind
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) since_toggle <= -1;
    else if ($changed(bclk_i)) since_toggle <= 0;
    else since_toggle <= since_toggle + 1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loopback_q <= 1'b0;
    end else if (awvalid_i && awready_i && wvalid_i && wready_i &&
                 awaddr_i == i2s_pkg::REG_CTRL) begin
      loopback_q <= wdata_lsb_i;
    end
  end

  loopback_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    loopback_q |-> dac_sdata_i == adc_sdata_i)
    else begin
      $error("loopback path broken");
      fails++;
    end

  rx_valid_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_valid_i |=> !rx_valid_i)
    else begin
      $error("rx_valid longer than one cycle");
      fails++;
    end

  bvalid_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      $error("bvalid dropped before bready");
      fails++;
    end

  rvalid_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i && !rready_i |=> rvalid_i)
    else begin
      $error("rvalid dropped before rready");
      fails++;
    end

  bclk_period_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $changed(bclk_i) |-> since_toggle == i2s_pkg::BCLK_HALF - 1)
    else begin
      $error("bit clock half period wrong");
      fails++;
    end

endmodule

/* design/i2s_codec_top.sv */
`timescale 1ns/1ps

module i2s_codec_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [i2s_pkg::ADDR_WIDTH-1:0] s_axil_awaddr_i,
  input  logic                           s_axil_awvalid_i,
  output logic                           s_axil_awready_o,
  input  logic [i2s_pkg::DATA_WIDTH-1:0] s_axil_wdata_i,
  input  logic                           s_axil_wvalid_i,
  output logic                           s_axil_wready_o,
  output logic [1:0]                     s_axil_bresp_o,
  output logic                           s_axil_bvalid_o,
  input  logic                           s_axil_bready_i,
  input  logic [i2s_pkg::ADDR_WIDTH-1:0] s_axil_araddr_i,
  input  logic                           s_axil_arvalid_i,
  output logic                           s_axil_arready_o,
  output logic [i2s_pkg::DATA_WIDTH-1:0] s_axil_rdata_o,
  output logic [1:0]                     s_axil_rresp_o,
  output logic                           s_axil_rvalid_o,
  input  logic                           s_axil_rready_i,
  output logic                           mclk_o,
  output logic                           bclk_o,
  output logic                           lrclk_o,
  input  logic                           adc_sdata_i,
  output logic                           dac_sdata_o,
  output logic                           rx_valid_o
);

  logic                         loopback_en;
  logic [i2s_pkg::TX_WIDTH-1:0] tx_left;
  logic [i2s_pkg::TX_WIDTH-1:0] tx_right;
  logic                         bclk_rise;
  logic                         bclk_fall;
  logic                         lrclk_rise;
  logic                         lrclk_fall;
  logic                         lrclk;
  logic [i2s_pkg::RX_WIDTH-1:0] rx_left;
  logic [i2s_pkg::RX_WIDTH-1:0] rx_right;
  logic                         rx_valid;

  assign lrclk_o    = lrclk;
  assign rx_valid_o = rx_valid;

  i2s_axil_regs regs_i (
    .clk_i,
    .rst_ni,
    .s_axil_awaddr_i,
    .s_axil_awvalid_i,
    .s_axil_awready_o,
    .s_axil_wdata_i,
    .s_axil_wvalid_i,
    .s_axil_wready_o,
    .s_axil_bresp_o,
    .s_axil_bvalid_o,
    .s_axil_bready_i,
    .s_axil_araddr_i,
    .s_axil_arvalid_i,
    .s_axil_arready_o,
    .s_axil_rdata_o,
    .s_axil_rresp_o,
    .s_axil_rvalid_o,
    .s_axil_rready_i,
    .rx_left_i     (rx_left),
    .rx_right_i    (rx_right),
    .rx_valid_i    (rx_valid),
    .loopback_en_o (loopback_en),
    .tx_left_o     (tx_left),
    .tx_right_o    (tx_right)
  );

  i2s_clock_gen clk_gen_i (
    .clk_i,
    .rst_ni,
    .mclk_o,
    .bclk_o,
    .lrclk_o      (lrclk),
    .bclk_rise_o  (bclk_rise),
    .bclk_fall_o  (bclk_fall),
    .lrclk_rise_o (lrclk_rise),
    .lrclk_fall_o (lrclk_fall)
  );

  i2s_transmitter tx_i (
    .clk_i,
    .rst_ni,
    .bclk_fall_i   (bclk_fall),
    .lrclk_rise_i  (lrclk_rise),
    .lrclk_fall_i  (lrclk_fall),
    .loopback_en_i (loopback_en),
    .adc_sdata_i,
    .tx_left_i     (tx_left),
    .tx_right_i    (tx_right),
    .dac_sdata_o
  );

  // Receiver listens to the ADC line even in loopback
  i2s_receiver rx_i (
    .clk_i,
    .rst_ni,
    .bclk_rise_i  (bclk_rise),
    .lrclk_rise_i (lrclk_rise),
    .lrclk_fall_i (lrclk_fall),
    .lrclk_i      (lrclk),
    .adc_sdata_i,
    .rx_left_o    (rx_left),
    .rx_right_o   (rx_right),
    .rx_valid_o   (rx_valid)
  );

endmodule

/* design/i2s_axil_regs.sv */
`timescale 1ns/1ps

module i2s_axil_regs (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [i2s_pkg::ADDR_WIDTH-1:0] s_axil_awaddr_i,
  input  logic                           s_axil_awvalid_i,
  output logic                           s_axil_awready_o,
  input  logic [i2s_pkg::DATA_WIDTH-1:0] s_axil_wdata_i,
  input  logic                           s_axil_wvalid_i,
  output logic                           s_axil_wready_o,
  output logic [1:0]                     s_axil_bresp_o,
  output logic                           s_axil_bvalid_o,
  input  logic                           s_axil_bready_i,
  input  logic [i2s_pkg::ADDR_WIDTH-1:0] s_axil_araddr_i,
  input  logic                           s_axil_arvalid_i,
  output logic                           s_axil_arready_o,
  output logic [i2s_pkg::DATA_WIDTH-1:0] s_axil_rdata_o,
  output logic [1:0]                     s_axil_rresp_o,
  output logic                           s_axil_rvalid_o,
  input  logic                           s_axil_rready_i,
  input  logic [i2s_pkg::RX_WIDTH-1:0]   rx_left_i,
  input  logic [i2s_pkg::RX_WIDTH-1:0]   rx_right_i,
  input  logic                           rx_valid_i,
  output logic                           loopback_en_o,
  output logic [i2s_pkg::TX_WIDTH-1:0]   tx_left_o,
  output logic [i2s_pkg::TX_WIDTH-1:0]   tx_right_o
);

  logic                           frame_flag;
  logic                           aw_take;
  logic                           ar_take;
  logic                           wr_en;
  logic                           rd_en;
  logic [i2s_pkg::DATA_WIDTH-1:0] rd_data;

  function automatic logic is_mapped(input logic [i2s_pkg::ADDR_WIDTH-1:0] addr);
    return addr inside {i2s_pkg::REG_CTRL, i2s_pkg::REG_TX_LEFT, i2s_pkg::REG_TX_RIGHT,
                        i2s_pkg::REG_RX_LEFT, i2s_pkg::REG_RX_RIGHT, i2s_pkg::REG_STATUS};
  endfunction

  // Accept only with both AW and W present and B free
  assign aw_take = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_awready_o && !s_axil_bvalid_o;
  assign ar_take = s_axil_arvalid_i && !s_axil_arready_o && !s_axil_rvalid_o;
  assign wr_en   = s_axil_awready_o && s_axil_awvalid_i && s_axil_wready_o && s_axil_wvalid_i;
  assign rd_en   = s_axil_arready_o && s_axil_arvalid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s_axil_awready_o <= 1'b0;
      s_axil_wready_o  <= 1'b0;
      s_axil_bvalid_o  <= 1'b0;
      s_axil_bresp_o   <= 2'b00;
    end else begin
      s_axil_awready_o <= aw_take;  // One-cycle ready pulse
      s_axil_wready_o  <= aw_take;
      if (wr_en) begin
        s_axil_bvalid_o <= 1'b1;
        s_axil_bresp_o  <= is_mapped(s_axil_awaddr_i) ? 2'b00 : 2'b10;  // OKAY / SLVERR
      end else if (s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;
      end
    end
  end

  // Register file and sticky status
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loopback_en_o <= 1'b0;
      tx_left_o     <= '0;
      tx_right_o    <= '0;
      frame_flag    <= 1'b0;
    end else begin
      if (wr_en) begin
        case (s_axil_awaddr_i)
          i2s_pkg::REG_CTRL:     loopback_en_o <= s_axil_wdata_i[0];
          i2s_pkg::REG_TX_LEFT:  tx_left_o  <= s_axil_wdata_i[i2s_pkg::TX_WIDTH-1:0];
          i2s_pkg::REG_TX_RIGHT: tx_right_o <= s_axil_wdata_i[i2s_pkg::TX_WIDTH-1:0];
          default: ;  // RX words are read only
        endcase
      end
      // A new frame wins over a clear in the same cycle
      if (rx_valid_i) begin
        frame_flag <= 1'b1;
      end else if (wr_en && s_axil_awaddr_i == i2s_pkg::REG_STATUS && s_axil_wdata_i[0]) begin
        frame_flag <= 1'b0;
      end
    end
  end

  always_comb begin
    rd_data = '0;
    case (s_axil_araddr_i)
      i2s_pkg::REG_CTRL:     rd_data[0] = loopback_en_o;
      i2s_pkg::REG_TX_LEFT:  rd_data[i2s_pkg::TX_WIDTH-1:0] = tx_left_o;
      i2s_pkg::REG_TX_RIGHT: rd_data[i2s_pkg::TX_WIDTH-1:0] = tx_right_o;
      i2s_pkg::REG_RX_LEFT:  rd_data[i2s_pkg::RX_WIDTH-1:0] = rx_left_i;
      i2s_pkg::REG_RX_RIGHT: rd_data[i2s_pkg::RX_WIDTH-1:0] = rx_right_i;
      i2s_pkg::REG_STATUS:   rd_data[0] = frame_flag;
      default:               rd_data = '0;
    endcase
  end

  // Read data is held stable while rvalid waits for rready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s_axil_arready_o <= 1'b0;
      s_axil_rvalid_o  <= 1'b0;
      s_axil_rdata_o   <= '0;
      s_axil_rresp_o   <= 2'b00;
    end else begin
      s_axil_arready_o <= ar_take;
      if (rd_en) begin
        s_axil_rvalid_o <= 1'b1;
        s_axil_rdata_o  <= rd_data;
        s_axil_rresp_o  <= is_mapped(s_axil_araddr_i) ? 2'b00 : 2'b10;
      end else if (s_axil_rready_i) begin
        s_axil_rvalid_o <= 1'b0;
      end
    end
  end

endmodule

/* design/i2s_receiver.sv */
`timescale 1ns/1ps

module i2s_receiver (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         bclk_rise_i,
  input  logic                         lrclk_rise_i,
  input  logic                         lrclk_fall_i,
  input  logic                         lrclk_i,
  input  logic                         adc_sdata_i,
  output logic [i2s_pkg::RX_WIDTH-1:0] rx_left_o,
  output logic [i2s_pkg::RX_WIDTH-1:0] rx_right_o,
  output logic                         rx_valid_o
);

  // Count 0 is the skipped delay bit, 1..RX_WIDTH are data bits
  localparam int CNT_W = $clog2(i2s_pkg::RX_WIDTH + 3);
  localparam logic [CNT_W-1:0] LAST_BIT  = CNT_W'(i2s_pkg::RX_WIDTH);
  localparam logic [CNT_W-1:0] STORE_CNT = CNT_W'(i2s_pkg::RX_WIDTH + 1);

  logic [CNT_W-1:0]             bit_cnt;
  logic [i2s_pkg::RX_WIDTH-1:0] shift_q;
  logic                         lr_edge;
  logic                         take_bit;

  assign lr_edge  = lrclk_rise_i | lrclk_fall_i;
  assign take_bit = bclk_rise_i && !lr_edge && (bit_cnt != '0) && (bit_cnt <= LAST_BIT);

  // Data shifter, fully refilled every word
  always_ff @(posedge clk_i) begin
    if (take_bit) shift_q <= {shift_q[i2s_pkg::RX_WIDTH-2:0], adc_sdata_i};
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt    <= '0;
      rx_left_o  <= '0;
      rx_right_o <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;  // Single-cycle pulse
      if (lr_edge) begin
        bit_cnt <= '0;
      end else if (bclk_rise_i) begin
        if (bit_cnt <= LAST_BIT) begin
          bit_cnt <= bit_cnt + 1'b1;
        end else if (bit_cnt == STORE_CNT) begin
          bit_cnt <= bit_cnt + 1'b1;  // Parks until next word
          // Word-select high means right channel
          if (lrclk_i) begin
            rx_right_o <= shift_q;
            rx_valid_o <= 1'b1;
          end else begin
            rx_left_o <= shift_q;
          end
        end
      end
    end
  end

endmodule

/* design/i2s_transmitter.sv */
`timescale 1ns/1ps

module i2s_transmitter (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         bclk_fall_i,
  input  logic                         lrclk_rise_i,
  input  logic                         lrclk_fall_i,
  input  logic                         loopback_en_i,
  input  logic                         adc_sdata_i,
  input  logic [i2s_pkg::TX_WIDTH-1:0] tx_left_i,
  input  logic [i2s_pkg::TX_WIDTH-1:0] tx_right_i,
  output logic                         dac_sdata_o
);

  // Extra top bit is the one-bit I2S delay slot
  logic [i2s_pkg::TX_WIDTH:0] shift_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q <= '0;
    end else if (lrclk_rise_i) begin
      shift_q <= {1'b0, tx_right_i};  // Right channel starts
    end else if (lrclk_fall_i) begin
      shift_q <= {1'b0, tx_left_i};   // Left channel starts
    end else if (bclk_fall_i) begin
      // Zeros fill in behind the LSB
      shift_q <= {shift_q[i2s_pkg::TX_WIDTH-1:0], 1'b0};
    end
  end

  // Loopback bypasses the shifter entirely
  assign dac_sdata_o = loopback_en_i ? adc_sdata_i : shift_q[i2s_pkg::TX_WIDTH];

endmodule

/* design/i2s_clock_gen.sv */
`timescale 1ns/1ps

module i2s_clock_gen (
  input  logic clk_i,
  input  logic rst_ni,
  output logic mclk_o,
  output logic bclk_o,
  output logic lrclk_o,
  output logic bclk_rise_o,
  output logic bclk_fall_o,
  output logic lrclk_rise_o,
  output logic lrclk_fall_o
);

  localparam int BCLK_CNT_W  = $clog2(i2s_pkg::BCLK_HALF);
  localparam int LRCLK_CNT_W = $clog2(i2s_pkg::LRCLK_HALF);

  localparam logic [BCLK_CNT_W-1:0]  BCLK_RELOAD  = BCLK_CNT_W'(i2s_pkg::BCLK_HALF - 1);
  localparam logic [LRCLK_CNT_W-1:0] LRCLK_RELOAD = LRCLK_CNT_W'(i2s_pkg::LRCLK_HALF - 1);

  logic [BCLK_CNT_W-1:0]  bclk_cnt;
  logic [LRCLK_CNT_W-1:0] lrclk_cnt;

  // Master clock is clk_i / 2
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) mclk_o <= 1'b0;
    else         mclk_o <= ~mclk_o;
  end

  // Both counters run down and flip their clock at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bclk_cnt  <= BCLK_RELOAD;
      bclk_o    <= 1'b0;
      lrclk_cnt <= LRCLK_RELOAD;
      lrclk_o   <= 1'b0;
    end else begin
      if (bclk_cnt == '0) begin
        bclk_cnt <= BCLK_RELOAD;
        bclk_o   <= ~bclk_o;
      end else begin
        bclk_cnt <= bclk_cnt - 1'b1;
      end
      if (lrclk_cnt == '0) begin
        lrclk_cnt <= LRCLK_RELOAD;
        lrclk_o   <= ~lrclk_o;
      end else begin
        lrclk_cnt <= lrclk_cnt - 1'b1;
      end
    end
  end

  // Strobes lead the actual toggle by one cycle
  assign bclk_rise_o  = (bclk_cnt == '0) && !bclk_o;
  assign bclk_fall_o  = (bclk_cnt == '0) &&  bclk_o;
  assign lrclk_rise_o = (lrclk_cnt == '0) && !lrclk_o;
  assign lrclk_fall_o = (lrclk_cnt == '0) &&  lrclk_o;

endmodule

/* design/i2s_pkg.sv */
package i2s_pkg;

  // Clock dividers in system clocks per half period
  localparam int BCLK_HALF  = 9;
  localparam int LRCLK_HALF = 567;

  // Sample widths
  localparam int TX_WIDTH = 24;  // Sent to the DAC
  localparam int RX_WIDTH = 16;  // Kept from the ADC

  // AXI4-Lite bus
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;

  // Register map
  localparam logic [7:0] REG_CTRL     = 8'h00;  // Bit 0 loopback
  localparam logic [7:0] REG_TX_LEFT  = 8'h04;
  localparam logic [7:0] REG_TX_RIGHT = 8'h08;
  localparam logic [7:0] REG_RX_LEFT  = 8'h0C;  // Read only
  localparam logic [7:0] REG_RX_RIGHT = 8'h10;  // Read only
  localparam logic [7:0] REG_STATUS   = 8'h14;  // Bit 0 frame flag, W1C

endpackage
